// ==== source/opl_macros.svh ====
//==========================================================================
// shared constants for the fm sound generator
// per-channel register bases take the channel offset 0..3 added in
// channel index inside the chip is bank * OPL_CH_PER_BANK + offset
// OPL_SAMPLE_DIV must be at least 2, OPL_T2_PRESCALE a power of two
//==========================================================================
`ifndef OPL_MACROS_SVH
`define OPL_MACROS_SVH

`define OPL_DATA_W        8      // host bus and register byte
`define OPL_NUM_BANKS     2
`define OPL_CH_PER_BANK   4
`define OPL_NUM_CH        8      // banks * channels per bank
`define OPL_FNUM_W        10     // frequency number
`define OPL_BLOCK_W       3      // octave shift
`define OPL_TL_W          6      // total level
`define OPL_PHASE_W       16     // phase accumulator
`define OPL_SAMPLE_W      16     // signed sample
`define OPL_SAMPLE_DIV    16     // clk cycles per sample tick
`define OPL_T2_PRESCALE   4      // sample ticks per timer 2 step

`define OPL_REG_TIMER1    8'h02
`define OPL_REG_TIMER2    8'h03
`define OPL_REG_TIMER_CTL 8'h04
`define OPL_REG_TL        8'h40  // + channel offset
`define OPL_REG_FNUM_LO   8'hA0  // + channel offset
`define OPL_REG_KON_BLOCK 8'hB0  // + channel offset
`define OPL_REG_WS        8'hE0  // + channel offset

`endif

// ==== source/opl_pkg.sv ====
//==========================================================================
// types shared across the fm sound generator blocks
// all structs are packed, msb field first
// timer load values are one register byte wide
//==========================================================================
`default_nettype none

`include "opl_macros.svh"

package opl_pkg;

    // one host register write, valid for a single cycle
    typedef struct packed {
        logic                   valid; // write strobe
        logic                   bank;  // 0 = left bank, 1 = right bank
        logic [`OPL_DATA_W-1:0] index; // register address
        logic [`OPL_DATA_W-1:0] data;  // register byte
    } reg_wr_t;

    // settings of one tone channel
    typedef struct packed {
        logic                    kon;   // key on
        logic [`OPL_BLOCK_W-1:0] block; // octave shift
        logic [`OPL_FNUM_W-1:0]  fnum;  // phase increment base
        logic [`OPL_TL_W-1:0]    tl;    // upper bits set attenuation
        logic                    ws;    // 0 square, 1 sawtooth
    } chan_ctl_t;

    typedef struct packed {
        logic [`OPL_DATA_W-1:0] timer1; // load value timer 1
        logic [`OPL_DATA_W-1:0] timer2; // load value timer 2
        logic                   st1;    // start/run
        logic                   st2;
        logic                   mt1;    // mask flag
        logic                   mt2;
        logic                   irq_rst; // one-cycle flag clear
    } timer_ctl_t;

    typedef struct packed {
        logic ft1; // timer 1 overflowed
        logic ft2; // timer 2 overflowed
        logic irq; // either flag set
    } timer_stat_t;

endpackage

`default_nettype wire

// ==== source/host_if.sv ====
//==========================================================================
// 8-bit chip port, all inputs sampled on clk
// address[0] picks index (0) or data (1) port, address[1] picks bank
// bank comes from the last index write, not from the data write
// data write shows on reg_wr one cycle later, status read is async
//==========================================================================
`timescale 1ns/1ns
`default_nettype none

`include "opl_macros.svh"

module host_if (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   cs_n,
    input  logic                   wr_n,
    input  logic                   rd_n,
    input  logic [1:0]             address,
    input  logic [`OPL_DATA_W-1:0] din,
    input  opl_pkg::timer_stat_t   stat,
    output logic [`OPL_DATA_W-1:0] dout,
    output opl_pkg::reg_wr_t       reg_wr
);

    logic [`OPL_DATA_W-1:0] index_q; // latched register index
    logic                   bank_q;  // latched bank select
    logic                   wr_cyc;  // host write this cycle
    logic                   rd_act;  // host read active

    assign wr_cyc = !cs_n && !wr_n;
    assign rd_act = !cs_n && !rd_n;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            index_q <= '0;
            bank_q  <= 1'b0;
        end else if (wr_cyc && !address[0]) begin // index port
            index_q <= din;
            bank_q  <= address[1];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            reg_wr <= '0;
        end else begin
            reg_wr.valid <= wr_cyc && address[0]; // data port strobe
            if (wr_cyc && address[0]) begin
                reg_wr.bank  <= bank_q;
                reg_wr.index <= index_q;
                reg_wr.data  <= din;
            end
        end
    end

    // status byte: irq, ft1, ft2 in the top bits
    assign dout = rd_act ? {stat.irq, stat.ft1, stat.ft2, {(`OPL_DATA_W-3){1'b0}}} : '0;

endmodule

`default_nettype wire

// ==== source/register_file.sv ====
//==========================================================================
// decodes register writes into channel and timer control
// per-channel ranges are base .. base+3, channel = bank * 4 + offset
// timer registers ignore the bank bit
// 04h with bit 7 set only clears the flags, other bits are dropped
//==========================================================================
`timescale 1ns/1ns
`default_nettype none

`include "opl_macros.svh"

module register_file (
    input  logic                 clk,
    input  logic                 rst_n,
    input  opl_pkg::reg_wr_t     reg_wr,
    output opl_pkg::chan_ctl_t   chan_ctl [`OPL_NUM_CH],
    output opl_pkg::timer_ctl_t  tmr_ctl
);

    localparam int BANK_W = $clog2(`OPL_NUM_BANKS);
    localparam int OFS_W  = $clog2(`OPL_CH_PER_BANK);
    localparam int CH_W   = BANK_W + OFS_W;

    logic [CH_W-1:0]        ch;   // target channel
    logic [`OPL_DATA_W-1:0] base; // index with offset stripped

    always_comb begin
        ch   = {reg_wr.bank, reg_wr.index[OFS_W-1:0]};
        base = {reg_wr.index[`OPL_DATA_W-1:OFS_W], {OFS_W{1'b0}}};
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `OPL_NUM_CH; i++) begin
                chan_ctl[i] <= '0;
            end
            tmr_ctl <= '0;
        end else begin
            tmr_ctl.irq_rst <= 1'b0; // pulse only
            if (reg_wr.valid) begin
                case (base)
                    `OPL_REG_TL:      chan_ctl[ch].tl <= reg_wr.data[`OPL_TL_W-1:0];
                    `OPL_REG_FNUM_LO: chan_ctl[ch].fnum[`OPL_DATA_W-1:0] <= reg_wr.data;
                    `OPL_REG_KON_BLOCK: begin
                        chan_ctl[ch].kon   <= reg_wr.data[5];
                        chan_ctl[ch].block <= reg_wr.data[4:2];
                        chan_ctl[ch].fnum[`OPL_FNUM_W-1:`OPL_DATA_W] <= reg_wr.data[1:0];
                    end
                    `OPL_REG_WS:      chan_ctl[ch].ws <= reg_wr.data[0];
                    default: ;        // unmapped, ignore
                endcase
                case (reg_wr.index)
                    `OPL_REG_TIMER1: tmr_ctl.timer1 <= reg_wr.data;
                    `OPL_REG_TIMER2: tmr_ctl.timer2 <= reg_wr.data;
                    `OPL_REG_TIMER_CTL: begin
                        if (reg_wr.data[7]) begin
                            tmr_ctl.irq_rst <= 1'b1; // flag clear
                        end else begin
                            tmr_ctl.mt1 <= reg_wr.data[6];
                            tmr_ctl.mt2 <= reg_wr.data[5];
                            tmr_ctl.st2 <= reg_wr.data[1];
                            tmr_ctl.st1 <= reg_wr.data[0];
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/timers.sv ====
//==========================================================================
// two 8-bit up-counting interval timers
// a rising st bit loads the counter, overflow past FFh reloads it
// timer 1 steps every sample tick, timer 2 every OPL_T2_PRESCALE ticks
// masked timers still count but never raise their flag
//==========================================================================
`timescale 1ns/1ns
`default_nettype none

`include "opl_macros.svh"

module timers (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 sample_tick,
    input  opl_pkg::timer_ctl_t  tmr_ctl,
    output opl_pkg::timer_stat_t stat
);

    localparam int PS_W = $clog2(`OPL_T2_PRESCALE);
    localparam logic [PS_W-1:0] PS_LAST = PS_W'(`OPL_T2_PRESCALE - 1);

    logic [`OPL_DATA_W-1:0] cnt      [2]; // index 0 = timer 1
    logic [`OPL_DATA_W-1:0] load_val [2];
    logic [PS_W-1:0]        ps2;          // timer 2 prescaler
    logic [1:0]             st;
    logic [1:0]             st_q;         // for start edge
    logic [1:0]             mt;
    logic [1:0]             step;
    logic [1:0]             flag;

    always_comb begin
        st          = {tmr_ctl.st2, tmr_ctl.st1};
        mt          = {tmr_ctl.mt2, tmr_ctl.mt1};
        load_val[0] = tmr_ctl.timer1;
        load_val[1] = tmr_ctl.timer2;
        step[0]     = sample_tick;
        step[1]     = sample_tick && (ps2 == PS_LAST);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ps2 <= '0;
        end else if (st[1] && !st_q[1]) begin
            ps2 <= '0; // align to timer 2 start
        end else if (sample_tick) begin
            ps2 <= (ps2 == PS_LAST) ? '0 : ps2 + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt[0] <= '0;
            cnt[1] <= '0;
            st_q   <= '0;
            flag   <= '0;
        end else begin
            st_q <= st;
            for (int i = 0; i < 2; i++) begin
                if (st[i] && !st_q[i]) begin
                    cnt[i] <= load_val[i];          // start loads
                end else if (st[i] && step[i]) begin
                    if (cnt[i] == '1) begin
                        cnt[i] <= load_val[i];      // wrap reload
                        if (!mt[i]) flag[i] <= 1'b1;
                    end else begin
                        cnt[i] <= cnt[i] + 1'b1;
                    end
                end
            end
            if (tmr_ctl.irq_rst) flag <= '0; // clear wins over overflow
        end
    end

    always_comb begin
        stat.ft1 = flag[0];
        stat.ft2 = flag[1];
        stat.irq = |flag;
    end

endmodule

`default_nettype wire

// ==== source/sample_clk_div.sv ====
//==========================================================================
// sample tick generator, one-cycle pulse every OPL_SAMPLE_DIV clocks
// first pulse OPL_SAMPLE_DIV cycles after reset release
//==========================================================================
`timescale 1ns/1ns
`default_nettype none

`include "opl_macros.svh"

module sample_clk_div (
    input  logic clk,
    input  logic rst_n,
    output logic sample_tick
);

    localparam int DIV_W = $clog2(`OPL_SAMPLE_DIV);
    localparam logic [DIV_W-1:0] LAST = DIV_W'(`OPL_SAMPLE_DIV - 1);

    logic [DIV_W-1:0] cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt         <= '0;
            sample_tick <= 1'b0;
        end else begin
            sample_tick <= (cnt == LAST); // registered, glitch free
            cnt         <= (cnt == LAST) ? '0 : cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== source/channels.sv ====
//==========================================================================
// eight tone channels: phase accumulator, wave shaping, attenuation
// chan_out carries the sample for the phase the coming tick moves to,
// so the mixer can register it on the tick itself
// key-off clears the phase at once and mutes the channel
// attenuation is a shift by tl[5:3], no log table
//==========================================================================
`timescale 1ns/1ns
`default_nettype none

`include "opl_macros.svh"

module channels (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            sample_tick,
    input  opl_pkg::chan_ctl_t              chan_ctl [`OPL_NUM_CH],
    output logic signed [`OPL_SAMPLE_W-1:0] chan_out [`OPL_NUM_CH]
);

    localparam int SAW_W = 12; // phase bits used by sawtooth
    localparam int ATT_W = 3;  // tl bits used as shift
    localparam int PH_MSB = `OPL_PHASE_W - 1;
    localparam logic signed [`OPL_SAMPLE_W-1:0] SQ_AMP = 16'sd4096;

    logic        [`OPL_PHASE_W-1:0]  phase     [`OPL_NUM_CH];
    logic        [`OPL_PHASE_W-1:0]  phase_nxt [`OPL_NUM_CH];
    logic signed [`OPL_SAMPLE_W-1:0] raw       [`OPL_NUM_CH]; // unattenuated wave

    always_comb begin
        for (int i = 0; i < `OPL_NUM_CH; i++) begin
            // increment = fnum << block, wraps at phase width
            phase_nxt[i] = phase[i] + (`OPL_PHASE_W'(chan_ctl[i].fnum) << chan_ctl[i].block);
            if (chan_ctl[i].ws) begin
                raw[i] = {{(`OPL_SAMPLE_W-SAW_W){phase_nxt[i][PH_MSB]}},
                          phase_nxt[i][PH_MSB -: SAW_W]}; // signed top bits
            end else if (phase_nxt[i][PH_MSB]) begin
                raw[i] = -SQ_AMP; // second half
            end else begin
                raw[i] = SQ_AMP;
            end
            if (chan_ctl[i].kon) begin
                chan_out[i] = raw[i] >>> chan_ctl[i].tl[`OPL_TL_W-1 -: ATT_W];
            end else begin
                chan_out[i] = '0; // muted
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `OPL_NUM_CH; i++) begin
                phase[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `OPL_NUM_CH; i++) begin
                if (!chan_ctl[i].kon) begin
                    phase[i] <= '0;           // held while keyed off
                end else if (sample_tick) begin
                    phase[i] <= phase_nxt[i]; // advance once per tick
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/opl_top.sv ====
//==========================================================================
// top of the fm sound generator, single clock, async active-low reset
// bank 0 mixes into sample_l, bank 1 into sample_r, 16-bit wrapping
// sample_valid pulses one cycle after each sample tick, no back-pressure
// irq_n is low while either timer flag is set
//==========================================================================
`timescale 1ns/1ns
`default_nettype none

`include "opl_macros.svh"

module opl_top (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            cs_n,
    input  logic                            wr_n,
    input  logic                            rd_n,
    input  logic [1:0]                      address,
    input  logic [`OPL_DATA_W-1:0]          din,
    output logic [`OPL_DATA_W-1:0]          dout,
    output logic                            sample_valid,
    output logic signed [`OPL_SAMPLE_W-1:0] sample_l,
    output logic signed [`OPL_SAMPLE_W-1:0] sample_r,
    output logic                            irq_n
);

    opl_pkg::reg_wr_t                reg_wr;
    opl_pkg::chan_ctl_t              chan_ctl [`OPL_NUM_CH];
    opl_pkg::timer_ctl_t             tmr_ctl;
    opl_pkg::timer_stat_t            stat;
    logic                            sample_tick;
    logic signed [`OPL_SAMPLE_W-1:0] chan_out [`OPL_NUM_CH];
    logic signed [`OPL_SAMPLE_W-1:0] mix_l; // bank 0 sum
    logic signed [`OPL_SAMPLE_W-1:0] mix_r; // bank 1 sum

    host_if host_if (.*);

    register_file register_file (.*);

    timers timers (.*);

    sample_clk_div sample_clk_div (.*);

    channels channels (.*);

    always_comb begin
        mix_l = '0;
        mix_r = '0;
        for (int i = 0; i < `OPL_CH_PER_BANK; i++) begin
            mix_l += chan_out[i];
            mix_r += chan_out[i + `OPL_CH_PER_BANK];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sample_valid <= 1'b0;
            sample_l     <= '0;
            sample_r     <= '0;
        end else begin
            sample_valid <= sample_tick; // one cycle after tick
            if (sample_tick) begin
                sample_l <= mix_l;
                sample_r <= mix_r;
            end
        end
    end

    assign irq_n = !stat.irq;

endmodule

`default_nettype wire

// ==== tests/opl_top_assert.sv ====
//==========================================================================
// concurrent checks on the opl_top ports, bound into every opl_top
// reset state is checked on each clock after rst_n was sampled low
// failures also count up fail_count, which the testbench reads
//==========================================================================
`timescale 1ns/1ns
`default_nettype none

`include "opl_macros.svh"

module opl_top_assert (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   cs_n,
    input logic                   rd_n,
    input logic                   sample_valid,
    input logic                   irq_n,
    input logic [`OPL_DATA_W-1:0] dout
);

    int fail_count = 0; // assertion failures seen

    // one tick gives exactly one valid cycle
    assert property (@(posedge clk) disable iff (!rst_n) sample_valid |=> !sample_valid)
        else begin
            fail_count++;
            $error("sample_valid stayed high for two cycles");
        end

    assert property (@(posedge clk) $past(!rst_n) |-> irq_n && !sample_valid)
        else begin
            fail_count++;
            $error("irq_n or sample_valid not at reset value");
        end

    // status byte only while the host reads
    assert property (@(posedge clk) !(!cs_n && !rd_n) |-> dout == '0)
        else begin
            fail_count++;
            $error("dout not zero outside a read");
        end

endmodule

bind opl_top opl_top_assert props (.*);

`default_nettype wire

// ==== tests/opl_top_tb.sv ====
//==========================================================================
// testbench for opl_top, a table of register writes and sample counts
// each row starts right after a sample_valid and holds at most 6 writes,
// so every write lands before the next sample tick
// expected samples and status come from a model of the channel and
// timer rules, timer rows also carry a hand-worked status byte
//==========================================================================
`timescale 1ns/1ns
`default_nettype none

`include "opl_macros.svh"

module opl_top_tb;

    localparam int MAX_WR    = 6;
    localparam int RST_CYC   = 16;
    localparam int MARGIN_NS = 2000;
    localparam int CLK_NS    = 10;

    typedef struct packed {
        opl_pkg::reg_wr_t [MAX_WR-1:0] wr;       // writes, in order
        logic [3:0]                    n_wr;
        logic [7:0]                    n_smp;    // samples to check after
        logic                          chk_stat; // compare exp_stat at row end
        logic [7:0]                    exp_stat;
    } row_t;

    logic                            clk = 1'b0;
    logic                            rst_n;
    logic                            cs_n;
    logic                            wr_n;
    logic                            rd_n;
    logic [1:0]                      address;
    logic [`OPL_DATA_W-1:0]          din;
    logic [`OPL_DATA_W-1:0]          dout;
    logic                            sample_valid;
    logic signed [`OPL_SAMPLE_W-1:0] sample_l;
    logic signed [`OPL_SAMPLE_W-1:0] sample_r;
    logic                            irq_n;

    row_t        rows [$];
    row_t        cur;              // row under construction
    int          errors = 0;
    int          checks = 0;
    int          wd_ns = 0;
    bit          table_done = 1'b0;
    logic [31:0] seed = 32'h0798f5cf;
    time         last_sv = 0;      // when the previous sample_valid was seen

    // reference model state
    opl_pkg::chan_ctl_t ctl_m   [`OPL_NUM_CH];
    int                 phase_m [`OPL_NUM_CH];
    logic [7:0]         tload_m [2];        // index 0 = timer 1
    logic [7:0]         tcnt_m  [2];
    bit                 st_m    [2];
    bit                 mt_m    [2];
    bit                 ft_m    [2];
    int                 ps2_m;

    opl_top DUT (.*);

    always #5 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error: %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic begin_row(input int n_smp, input bit chk, input logic [7:0] exp);
        cur          = '0;
        cur.n_smp    = 8'(n_smp);
        cur.chk_stat = chk;
        cur.exp_stat = exp;
    endtask

    task automatic add_write(input logic bank, input logic [7:0] index,
                             input logic [7:0] data);
        cur.wr[cur.n_wr] = {1'b1, bank, index, data};
        cur.n_wr         = cur.n_wr + 4'd1;
    endtask

    task automatic end_row();
        rows.push_back(cur);
    endtask

    // index cycle then data cycle, one clock each
    task automatic host_write(input opl_pkg::reg_wr_t w);
        @(posedge clk);
        cs_n    <= 1'b0;
        wr_n    <= 1'b0;
        rd_n    <= 1'b1;
        address <= {w.bank, 1'b0};
        din     <= w.index;
        @(posedge clk);
        address <= {w.bank, 1'b1};
        din     <= w.data;
    endtask

    task automatic bus_idle();
        @(posedge clk);
        cs_n    <= 1'b1;
        wr_n    <= 1'b1;
        rd_n    <= 1'b1;
        address <= '0;
        din     <= '0;
    endtask

    task automatic read_status(output logic [7:0] val);
        @(posedge clk);
        cs_n <= 1'b0;
        rd_n <= 1'b0;
        wr_n <= 1'b1;
        @(negedge clk);
        val = dout; // combinational read, stable mid cycle
    endtask

    task automatic model_reset();
        for (int i = 0; i < `OPL_NUM_CH; i++) begin
            ctl_m[i]   = '0;
            phase_m[i] = 0;
        end
        for (int i = 0; i < 2; i++) begin
            tload_m[i] = '0;
            tcnt_m[i]  = '0;
            st_m[i]    = 1'b0;
            mt_m[i]    = 1'b0;
            ft_m[i]    = 1'b0;
        end
        ps2_m = 0;
    endtask

    function automatic bit in_range(input logic [7:0] idx, input int base);
        return (int'(idx) >= base) && (int'(idx) < base + `OPL_CH_PER_BANK);
    endfunction

    task automatic model_write(input opl_pkg::reg_wr_t w);
        int ch;
        ch = w.bank * `OPL_CH_PER_BANK + int'(w.index) % `OPL_CH_PER_BANK;
        if (in_range(w.index, `OPL_REG_TL)) begin
            ctl_m[ch].tl = w.data[5:0];
        end else if (in_range(w.index, `OPL_REG_FNUM_LO)) begin
            ctl_m[ch].fnum[7:0] = w.data;
        end else if (in_range(w.index, `OPL_REG_KON_BLOCK)) begin
            ctl_m[ch].kon       = w.data[5];
            ctl_m[ch].block     = w.data[4:2];
            ctl_m[ch].fnum[9:8] = w.data[1:0];
            if (!w.data[5]) phase_m[ch] = 0; // key off clears phase
        end else if (in_range(w.index, `OPL_REG_WS)) begin
            ctl_m[ch].ws = w.data[0];
        end else if (w.index == `OPL_REG_TIMER1) begin
            tload_m[0] = w.data;
        end else if (w.index == `OPL_REG_TIMER2) begin
            tload_m[1] = w.data;
        end else if (w.index == `OPL_REG_TIMER_CTL) begin
            if (w.data[7]) begin
                ft_m[0] = 1'b0; // flag clear only
                ft_m[1] = 1'b0;
            end else begin
                for (int i = 0; i < 2; i++) begin
                    if (w.data[i] && !st_m[i]) begin
                        tcnt_m[i] = tload_m[i]; // start loads
                        if (i == 1) ps2_m = 0;
                    end
                    st_m[i] = w.data[i];
                end
                mt_m[0] = w.data[6];
                mt_m[1] = w.data[5];
            end
        end
    endtask

    // one sample tick of the model, returns the expected bank sums
    task automatic model_tick(output logic [15:0] exp_l, output logic [15:0] exp_r);
        int sum [2];
        int raw;
        bit step;
        sum[0] = 0;
        sum[1] = 0;
        for (int i = 0; i < 2; i++) begin
            step = (i == 0) ? 1'b1 : (ps2_m == `OPL_T2_PRESCALE - 1);
            if (st_m[i] && step) begin
                if (tcnt_m[i] == 8'hFF) begin
                    tcnt_m[i] = tload_m[i];    // overflow reload
                    if (!mt_m[i]) ft_m[i] = 1'b1;
                end else begin
                    tcnt_m[i] = tcnt_m[i] + 8'd1;
                end
            end
        end
        ps2_m = (ps2_m + 1) % `OPL_T2_PRESCALE;
        for (int ch = 0; ch < `OPL_NUM_CH; ch++) begin
            if (!ctl_m[ch].kon) begin
                phase_m[ch] = 0;
            end else begin
                phase_m[ch] = (phase_m[ch] + (int'(ctl_m[ch].fnum) << ctl_m[ch].block)) & 'hFFFF;
                if (ctl_m[ch].ws) begin
                    raw = phase_m[ch] >> 4;            // top 12 bits
                    if (raw >= 2048) raw = raw - 4096; // as signed
                end else begin
                    raw = (phase_m[ch] >= 'h8000) ? -4096 : 4096;
                end
                raw = raw >>> ctl_m[ch].tl[5:3];
                sum[ch / `OPL_CH_PER_BANK] += raw;
            end
        end
        exp_l = 16'(sum[0]); // 16-bit wrap
        exp_r = 16'(sum[1]);
    endtask

    task automatic check_sample(output logic [7:0] stat);
        logic [15:0] exp_l;
        logic [15:0] exp_r;
        do @(negedge clk); while (sample_valid !== 1'b1);
        check_value("sample_valid period", 32'(($time - last_sv) / CLK_NS),
                    `OPL_SAMPLE_DIV);
        last_sv = $time;
        model_tick(exp_l, exp_r);
        check_value("sample_l", $unsigned(sample_l), exp_l);
        check_value("sample_r", $unsigned(sample_r), exp_r);
        check_value("irq_n", irq_n, !(ft_m[0] || ft_m[1]));
        read_status(stat);
        check_value("dout", stat, {ft_m[0] || ft_m[1], ft_m[0], ft_m[1], 5'b0});
    endtask

    task automatic build_table();
        int         ch;
        int         sel [6] = '{1, 2, 4, 7, 5, 3}; // both banks
        logic       bank;
        logic [1:0] ofs;
        begin_row(4, 1'b1, 8'h00);                  // idle after reset
        end_row();
        begin_row(40, 1'b0, 8'h00);                 // ch0 square, msb flips at 32
        add_write(1'b0, `OPL_REG_TL, 8'h00);
        add_write(1'b0, `OPL_REG_WS, 8'h00);
        add_write(1'b0, `OPL_REG_FNUM_LO, 8'h00);
        add_write(1'b0, `OPL_REG_KON_BLOCK, 8'h29); // kon, block 2, fnum 100h
        end_row();
        begin_row(3, 1'b0, 8'h00);
        add_write(1'b0, `OPL_REG_KON_BLOCK, 8'h09); // key off
        end_row();
        begin_row(5, 1'b0, 8'h00);
        add_write(1'b0, `OPL_REG_KON_BLOCK, 8'h29); // key on, phase from 0
        end_row();
        for (int i = 0; i < 6; i++) begin
            ch   = sel[i];
            bank = 1'(ch / `OPL_CH_PER_BANK);
            ofs  = 2'(ch % `OPL_CH_PER_BANK);
            seed = xorshift32(seed);
            begin_row(8, 1'b0, 8'h00);
            add_write(bank, `OPL_REG_FNUM_LO + ofs, seed[7:0]);
            add_write(bank, `OPL_REG_KON_BLOCK + ofs, {2'b00, 1'b1, seed[10:8], seed[12:11]});
            add_write(bank, `OPL_REG_TL + ofs, {2'b00, seed[18:13]});
            add_write(bank, `OPL_REG_WS + ofs, {7'b0, seed[19]});
            end_row();
        end
        begin_row(5, 1'b1, 8'hC0);                  // ft1 after 4 ticks
        add_write(1'b0, `OPL_REG_TIMER1, 8'hFC);
        add_write(1'b0, `OPL_REG_TIMER2, 8'hFF);
        add_write(1'b0, `OPL_REG_TIMER_CTL, 8'h23); // mask t2, start both
        end_row();
        begin_row(3, 1'b1, 8'h00);
        add_write(1'b0, `OPL_REG_TIMER_CTL, 8'h00); // stop
        add_write(1'b0, `OPL_REG_TIMER_CTL, 8'h80); // clear flags
        end_row();
    endtask

    initial begin
        logic [7:0] stat;
        int         total;
        rst_n   = 1'b0;
        cs_n    = 1'b1;
        wr_n    = 1'b1;
        rd_n    = 1'b1;
        address = '0;
        din     = '0;
        model_reset();
        build_table();
        total = 1; // sync sample
        foreach (rows[r]) total += rows[r].n_smp;
        wd_ns = total * `OPL_SAMPLE_DIV * 10 + RST_CYC * 10 + MARGIN_NS;
        table_done = 1'b1;
        repeat (RST_CYC) @(posedge clk);
        rst_n <= 1'b1;
        last_sv = $time + CLK_NS + CLK_NS / 2; // valid trails its tick, seen at negedge
        check_sample(stat); // first tick, nothing keyed
        foreach (rows[r]) begin
            for (int i = 0; i < rows[r].n_wr; i++) begin
                host_write(rows[r].wr[i]);
                model_write(rows[r].wr[i]);
            end
            bus_idle();
            for (int k = 0; k < rows[r].n_smp; k++) begin
                check_sample(stat);
            end
            if (rows[r].chk_stat) check_value("dout", stat, rows[r].exp_stat);
        end
        bus_idle();
        $display("errors: %0d in %0d checks, assertion failures: %0d",
                 errors, checks, DUT.props.fail_count);
        if (errors == 0 && DUT.props.fail_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    initial begin
        wait (table_done);
        #(wd_ns);
        $display("timeout: the sample stream stopped before the table was done");
        $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+source
source/opl_pkg.sv
source/host_if.sv
source/register_file.sv
source/timers.sv
source/sample_clk_div.sv
source/channels.sv
source/opl_top.sv
tests/opl_top_assert.sv
tests/opl_top_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the opl_top testbench with Verilator, run it, judge the log
verilator --binary --timing --assert -Wno-fatal -f all.f --top-module opl_top_tb \
    -o opl_sim > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/opl_sim > sim.log 2>&1 || echo "simulator returned an error status"
grep -q "^Result: PASSED$" sim.log && echo "simulation passed" || {
    echo "simulation failed, see sim.log"
    exit 1
}
